// File: engine_pkg.sv
// Read engine shared definitions
package engine_pkg;

    // ==========================================================
    // Widths
    // ==========================================================

    // Line address and R data
    localparam int ADDR_WIDTH       = 48;
    localparam int DATA_WIDTH       = 64;
    // Offset added to the base address
    localparam int OFFSET_WIDTH     = 32;
    localparam int BURST_WIDTH      = 16;
    // Lines in flight, also the quota width
    localparam int LINE_COUNT_WIDTH = 12;
    localparam int COUNTER_WIDTH    = 48;
    localparam int CSR_IDX_WIDTH    = 3;
    localparam int NUM_STATS        = 4;

    // Statistics counter slots
    localparam int STAT_RD_BURSTS_REQ   = 0;
    localparam int STAT_RD_LINES_RESP   = 1;
    localparam int STAT_RD_BURSTS_RESP  = 2;
    localparam int STAT_ACTIVE_LINE_SUM = 3;

    // ==========================================================
    // Register indices
    // ==========================================================

    // Write side
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_BASE_ADDR   = CSR_IDX_WIDTH'(0);
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_RD_CTRL     = CSR_IDX_WIDTH'(2);
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_OFFSET_MASK = CSR_IDX_WIDTH'(4);
    localparam logic [CSR_IDX_WIDTH-1:0] CSR_READY_MASK  = CSR_IDX_WIDTH'(6);

    // Status side
    localparam logic [CSR_IDX_WIDTH-1:0] STS_ACTIVE       = CSR_IDX_WIDTH'(0);
    localparam logic [CSR_IDX_WIDTH-1:0] STS_BURSTS_REQ   = CSR_IDX_WIDTH'(1);
    localparam logic [CSR_IDX_WIDTH-1:0] STS_LINES_RESP   = CSR_IDX_WIDTH'(2);
    localparam logic [CSR_IDX_WIDTH-1:0] STS_BURSTS_RESP  = CSR_IDX_WIDTH'(3);
    localparam logic [CSR_IDX_WIDTH-1:0] STS_CHECK        = CSR_IDX_WIDTH'(4);
    localparam logic [CSR_IDX_WIDTH-1:0] STS_ACTIVE_LINES = CSR_IDX_WIDTH'(5);

    // Read control word layout
    typedef struct packed {
        logic [15:0] max_lines;
        logic [15:0] bursts;
        logic [15:0] start_offset;
        logic [15:0] burst_len;
    } t_rd_ctrl;

    // One written word, raw or as read control fields
    typedef union packed {
        logic [63:0] raw;
        t_rd_ctrl    rd_ctrl;
    } t_csr_word;

    // Per-cycle increments, one per counter slot
    typedef logic [NUM_STATS-1:0][COUNTER_WIDTH-1:0] t_stat_vec;

endpackage

// File: stat_counter.sv
// Statistics accumulator
`timescale 1ns/1ps

module stat_counter
    import engine_pkg::*;
(
    input  logic                     clk,
    input  logic                     state_reset,
    input  logic [COUNTER_WIDTH-1:0] incr,
    output logic [COUNTER_WIDTH-1:0] value
);

    // Single-cycle add of the registered increment
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            value <= '0;
        end
        else
        begin
            value <= value + incr;
        end
    end

endmodule

// File: rd_engine_csr.sv
// Read engine register file
`timescale 1ns/1ps

module rd_engine_csr
    import engine_pkg::*;
(
    input  logic                        clk,
    input  logic                        state_reset,
    input  logic                        csr_wr,
    input  logic [CSR_IDX_WIDTH-1:0]    csr_idx,
    input  logic [63:0]                 csr_data,
    input  logic [CSR_IDX_WIDTH-1:0]    csr_rd_idx,
    input  logic                        active,
    input  t_stat_vec                   stat_values,
    input  logic [31:0]                 rd_sum,
    input  logic [31:0]                 rd_hash,
    output logic [ADDR_WIDTH-1:0]       base_addr,
    output logic [BURST_WIDTH-1:0]      burst_len,
    output logic [BURST_WIDTH-1:0]      num_bursts,
    output logic [OFFSET_WIDTH-1:0]     start_offset,
    output logic [OFFSET_WIDTH-1:0]     offset_mask,
    output logic [LINE_COUNT_WIDTH-1:0] max_lines,
    output logic [31:0]                 ready_mask,
    output logic [63:0]                 csr_rd_data
);

    // Written word, decoded raw or as read control fields
    t_csr_word wr_word;

    assign wr_word.raw = csr_data;

    // ==========================================================
    // Configuration registers
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (csr_wr)
        begin
            case (csr_idx)
                CSR_BASE_ADDR:
                begin
                    // Line address of the read buffer
                    base_addr <= wr_word.raw[ADDR_WIDTH-1:0];
                end
                CSR_RD_CTRL:
                begin
                    // Kept as limit minus one, so zero wraps to no limit
                    max_lines    <= wr_word.rd_ctrl.max_lines[LINE_COUNT_WIDTH-1:0]
                                    - LINE_COUNT_WIDTH'(1);
                    num_bursts   <= wr_word.rd_ctrl.bursts;
                    start_offset <= OFFSET_WIDTH'(wr_word.rd_ctrl.start_offset);
                    burst_len    <= wr_word.rd_ctrl.burst_len;
                end
                CSR_OFFSET_MASK:
                begin
                    offset_mask <= wr_word.raw[OFFSET_WIDTH-1:0];
                end
                default:
                begin
                end
            endcase
        end
    end

    // R ready mask, all ones after reset
    // A write in a reset cycle still lands, so a mask can go in with the reset
    always_ff @(posedge clk)
    begin
        if (csr_wr && (csr_idx == CSR_READY_MASK))
        begin
            ready_mask <= wr_word.raw[31:0];
        end
        else if (state_reset)
        begin
            ready_mask <= '1;
        end
    end

    // ==========================================================
    // Status read
    // ==========================================================

    always_comb
    begin
        case (csr_rd_idx)
            STS_ACTIVE:       csr_rd_data = 64'(active);
            STS_BURSTS_REQ:   csr_rd_data = 64'(stat_values[STAT_RD_BURSTS_REQ]);
            STS_LINES_RESP:   csr_rd_data = 64'(stat_values[STAT_RD_LINES_RESP]);
            STS_BURSTS_RESP:  csr_rd_data = 64'(stat_values[STAT_RD_BURSTS_RESP]);
            // Sum on top, hash below
            STS_CHECK:        csr_rd_data = {rd_sum, rd_hash};
            STS_ACTIVE_LINES: csr_rd_data = 64'(stat_values[STAT_ACTIVE_LINE_SUM]);
            default:          csr_rd_data = '0;
        endcase
    end

endmodule

// File: rd_req_gen.sv
// Read burst address generator
`timescale 1ns/1ps

module rd_req_gen
    import engine_pkg::*;
(
    input  logic                        clk,
    input  logic                        state_reset,
    input  logic                        run,
    input  logic [ADDR_WIDTH-1:0]       base_addr,
    input  logic [BURST_WIDTH-1:0]      burst_len,
    input  logic [BURST_WIDTH-1:0]      num_bursts,
    input  logic [OFFSET_WIDTH-1:0]     start_offset,
    input  logic [OFFSET_WIDTH-1:0]     offset_mask,
    input  logic                        quota_hit,
    input  logic                        arready,
    output logic                        arvalid,
    output logic [ADDR_WIDTH-1:0]       araddr,
    output logic [BURST_WIDTH-1:0]      arlen,
    output logic                        ar_fire,
    output logic                        done
);

    logic [OFFSET_WIDTH-1:0] cur_offset;
    // Bursts still allowed in this run
    logic [BURST_WIDTH-1:0]  bursts_left;
    logic                    unlimited;

    // Request whenever running, budget left and under quota
    assign arvalid = run && !done && !quota_hit;
    assign ar_fire = arvalid && arready;

    // Offset only moves on a transfer, so the address holds under back-pressure
    assign araddr  = base_addr + ADDR_WIDTH'(cur_offset);
    // AXI length encoding
    assign arlen   = burst_len - BURST_WIDTH'(1);

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cur_offset  <= start_offset;
            bursts_left <= num_bursts;
            // Zero bursts means run forever
            unlimited   <= (num_bursts == '0);
            // No buffer configured, nothing to do
            done        <= (base_addr == '0);
        end
        else if (ar_fire)
        begin
            // Wrap within the masked window
            cur_offset  <= (cur_offset + OFFSET_WIDTH'(burst_len)) & offset_mask;
            bursts_left <= bursts_left - BURST_WIDTH'(1);
            done        <= !unlimited && (bursts_left == BURST_WIDTH'(1));
        end
    end

endmodule

// File: rd_line_tracker.sv
// In-flight line accounting
`timescale 1ns/1ps

module rd_line_tracker
    import engine_pkg::*;
(
    input  logic                        clk,
    input  logic                        state_reset,
    input  logic                        ar_fire,
    input  logic [BURST_WIDTH-1:0]      burst_len,
    input  logic [LINE_COUNT_WIDTH-1:0] max_lines,
    input  logic                        r_fire,
    input  logic                        r_last_fire,
    output logic [LINE_COUNT_WIDTH-1:0] lines_in_flight,
    output logic                        quota_hit,
    output t_stat_vec                   stat_incr
);

    // Lines added by a request this cycle
    logic [LINE_COUNT_WIDTH-1:0] new_lines;
    // One extra bit so the compare sees overflow
    logic [LINE_COUNT_WIDTH:0]   lines_after_req;

    assign new_lines       = ar_fire ? LINE_COUNT_WIDTH'(burst_len) : '0;
    assign lines_after_req = {1'b0, lines_in_flight} + {1'b0, LINE_COUNT_WIDTH'(burst_len)};

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            lines_in_flight <= '0;
            quota_hit       <= 1'b0;
            stat_incr       <= '0;
        end
        else
        begin
            lines_in_flight <= lines_in_flight + new_lines - LINE_COUNT_WIDTH'(r_fire);

            // Compare picks its operand by ar_fire instead of adding new_lines
            // first, keeping the adder off the compare path
            quota_hit <= ar_fire ? (lines_after_req > {1'b0, max_lines})
                                 : (lines_in_flight > max_lines);

            // Registered increments for the counter array
            stat_incr[STAT_RD_BURSTS_REQ]   <= COUNTER_WIDTH'(ar_fire);
            stat_incr[STAT_RD_LINES_RESP]   <= COUNTER_WIDTH'(r_fire);
            stat_incr[STAT_RD_BURSTS_RESP]  <= COUNTER_WIDTH'(r_last_fire);
            stat_incr[STAT_ACTIVE_LINE_SUM] <= COUNTER_WIDTH'(lines_in_flight);
        end
    end

endmodule

// File: rd_resp_sink.sv
// R channel sink with data check
`timescale 1ns/1ps

module rd_resp_sink
    import engine_pkg::*;
(
    input  logic                  clk,
    input  logic                  state_reset,
    input  logic [31:0]           ready_mask_r,
    input  logic                  rvalid,
    input  logic                  rlast,
    input  logic [DATA_WIDTH-1:0] rdata,
    output logic                  rready,
    output logic                  r_fire,
    output logic                  r_last_fire,
    output logic [31:0]           rd_sum,
    output logic [31:0]           rd_hash
);

    // Rotating copy, bit 0 is this cycle's ready
    logic [31:0] rot_mask;
    // Top and bottom 16 bits of the beat
    logic [31:0] beat_word;

    assign rready      = rot_mask[0];
    assign r_fire      = rvalid && rready;
    assign r_last_fire = r_fire && rlast;
    assign beat_word   = {rdata[DATA_WIDTH-1 -: 16], rdata[15:0]};

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            rot_mask <= ready_mask_r;
            rd_sum   <= '0;
            rd_hash  <= '0;
        end
        else
        begin
            rot_mask <= {rot_mask[30:0], rot_mask[31]};
            if (r_fire)
            begin
                rd_sum  <= rd_sum + beat_word;
                // Order dependent, rotate left then fold in
                rd_hash <= {rd_hash[30:0], rd_hash[31]} ^ beat_word;
            end
        end
    end

endmodule

// File: rd_engine_top.sv
// Read traffic engine top level
`timescale 1ns/1ps

module rd_engine_top
    import engine_pkg::*;
(
    input  logic                     clk,
    input  logic                     state_reset,
    input  logic                     run,
    input  logic                     csr_wr,
    input  logic [CSR_IDX_WIDTH-1:0] csr_idx,
    input  logic [63:0]              csr_data,
    input  logic [CSR_IDX_WIDTH-1:0] csr_rd_idx,
    output logic [63:0]              csr_rd_data,
    output logic                     arvalid,
    input  logic                     arready,
    output logic [ADDR_WIDTH-1:0]    araddr,
    output logic [BURST_WIDTH-1:0]   arlen,
    input  logic                     rvalid,
    output logic                     rready,
    input  logic [DATA_WIDTH-1:0]    rdata,
    input  logic                     rlast
);

    // Configuration
    logic [ADDR_WIDTH-1:0]       base_addr;
    logic [BURST_WIDTH-1:0]      burst_len;
    logic [BURST_WIDTH-1:0]      num_bursts;
    logic [OFFSET_WIDTH-1:0]     start_offset;
    logic [OFFSET_WIDTH-1:0]     offset_mask;
    logic [LINE_COUNT_WIDTH-1:0] max_lines;
    logic [31:0]                 ready_mask;

    // Engine state and events
    logic                        ar_fire;
    logic                        done;
    logic                        quota_hit;
    logic [LINE_COUNT_WIDTH-1:0] lines_in_flight;
    logic                        r_fire;
    logic                        r_last_fire;
    logic [31:0]                 rd_sum;
    logic [31:0]                 rd_hash;
    logic                        active;
    t_stat_vec                   stat_incr;
    t_stat_vec                   stat_values;

    // Busy while issuing or while responses are owed
    assign active = (run && !done) || (lines_in_flight != '0);

    rd_engine_csr u_csr (.*);

    rd_req_gen u_req_gen (.*);

    rd_line_tracker u_tracker (.*);

    rd_resp_sink u_resp_sink (.*, .ready_mask_r(ready_mask));

    // ==========================================================
    // Statistics counters
    // ==========================================================

    for (genvar i = 0; i < NUM_STATS; i++)
    begin : g_stat
        stat_counter u_counter (
            .clk         (clk),
            .state_reset (state_reset),
            .incr        (stat_incr[i]),
            .value       (stat_values[i])
        );
    end

endmodule

// File: rd_engine_properties.sv
// AR and R handshake checks
`timescale 1ns/1ps

module rd_engine_properties
    import engine_pkg::*;
(
    input logic                   clk,
    input logic                   state_reset,
    input logic                   arvalid,
    input logic                   arready,
    input logic [ADDR_WIDTH-1:0]  araddr,
    input logic [BURST_WIDTH-1:0] arlen,
    input logic                   rvalid,
    input logic                   rready,
    input logic [DATA_WIDTH-1:0]  rdata,
    input logic                   rlast,
    input logic [31:0]            rd_sum,
    input logic [31:0]            rd_hash
);

    // AR request holds until taken
    ar_hold: assert property (@(posedge clk) disable iff (state_reset)
        (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)))
        else $error("AR request changed under back-pressure");

    // A refused beat leaves the sum and hash alone
    r_accept: assert property (@(posedge clk) disable iff (state_reset)
        (rvalid && !rready) |=> ($stable(rd_sum) && $stable(rd_hash)))
        else $error("R beat absorbed while rready low");

    // Refused beat waits at the source
    r_hold: assert property (@(posedge clk) disable iff (state_reset)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rlast)))
        else $error("R beat changed while rready low");

endmodule

// File: tb_rd_engine.sv
// Read engine testbench
`timescale 1ns/1ps

module tb_rd_engine
    import engine_pkg::*;
;

    localparam int CLK_PERIOD  = 10;
    localparam int SEED        = 87443;
    // Rough length of all tests together, in cycles
    localparam int TEST_CYCLES = 600;
    localparam int IDLE_LIMIT  = 1000;

    logic                     clk;
    logic                     state_reset;
    logic                     run;
    logic                     csr_wr;
    logic [CSR_IDX_WIDTH-1:0] csr_idx;
    logic [63:0]              csr_data;
    logic [CSR_IDX_WIDTH-1:0] csr_rd_idx;
    logic [63:0]              csr_rd_data;
    logic                     arvalid;
    logic                     arready = 1'b0;
    logic [ADDR_WIDTH-1:0]    araddr;
    logic [BURST_WIDTH-1:0]   arlen;
    logic                     rvalid = 1'b0;
    logic                     rready;
    logic [DATA_WIDTH-1:0]    rdata = '0;
    logic                     rlast = 1'b0;

    // Monitor results, cleared on reset
    logic [ADDR_WIDTH-1:0]    seen_addr[$];
    logic [ADDR_WIDTH-1:0]    pend_addr[$];
    logic [BURST_WIDTH-1:0]   pend_len[$];
    int                       beat_count;
    int                       last_count;
    int                       in_flight;
    int                       peak_in_flight;
    int                       line_cycle_sum;
    int                       mask_errors;
    logic [31:0]              exp_sum;
    logic [31:0]              exp_hash;
    logic [31:0]              mask_load;
    logic [31:0]              mask_model;
    bit                       mask_check_en;
    bit                       ar_taken;
    bit                       r_taken;
    bit                       rst_seen;

    // Responder state
    logic [ADDR_WIDTH-1:0]    cur_addr = '0;
    logic [BURST_WIDTH-1:0]   cur_len = '0;
    logic [BURST_WIDTH-1:0]   beat_idx = '0;
    bit                       r_busy;

    int                       errors;
    int                       tests_run;
    string                    test_name;

    rd_engine_top u_rd_engine_top (.*);

    bind rd_engine_top rd_engine_properties u_props (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==========================================================
    // Monitor and memory responder
    // ==========================================================

    // Mid-cycle sample, these handshakes complete at the next rising edge
    always @(negedge clk)
    begin : monitor
        logic [31:0] word;
        ar_taken = arvalid && arready;
        r_taken  = rvalid && rready;
        rst_seen = state_reset;
        if (state_reset)
        begin
            seen_addr.delete();
            pend_addr.delete();
            pend_len.delete();
            beat_count     = 0;
            last_count     = 0;
            in_flight      = 0;
            peak_in_flight = 0;
            line_cycle_sum = 0;
            exp_sum        = '0;
            exp_hash       = '0;
            mask_model     = mask_load;
            mask_check_en  = 1'b1;
        end
        else
        begin
            // Lines owed during this cycle, before its own handshakes
            line_cycle_sum += in_flight;
            if (ar_taken)
            begin
                seen_addr.push_back(araddr);
                pend_addr.push_back(araddr);
                pend_len.push_back(arlen);
                in_flight += int'(arlen) + 1;
            end
            if (r_taken)
            begin
                // Sum and hash rule of the R sink
                word     = {rdata[DATA_WIDTH-1 -: 16], rdata[15:0]};
                exp_sum  = exp_sum + word;
                exp_hash = {exp_hash[30:0], exp_hash[31]} ^ word;
                beat_count++;
                in_flight--;
                if (rlast)
                begin
                    last_count++;
                end
            end
            if (in_flight > peak_in_flight)
            begin
                peak_in_flight = in_flight;
            end
            // rready walks the loaded mask, one bit per cycle
            if (mask_check_en)
            begin
                if (rready !== mask_model[0])
                begin
                    $display("mismatch %s: rready expected %0b actual %0b",
                             test_name, mask_model[0], rready);
                    mask_errors++;
                end
                mask_model = {mask_model[30:0], mask_model[31]};
            end
        end
    end

    // Beat data is line address plus beat number
    always @(posedge clk)
    begin
        #1;
        if (rst_seen)
        begin
            r_busy = 1'b0;
        end
        else if (r_taken)
        begin
            if (beat_idx == cur_len)
            begin
                r_busy = 1'b0;
            end
            else
            begin
                beat_idx = beat_idx + BURST_WIDTH'(1);
            end
        end
        if (!rst_seen && !r_busy && (pend_addr.size() > 0))
        begin
            cur_addr = pend_addr.pop_front();
            cur_len  = pend_len.pop_front();
            beat_idx = '0;
            r_busy   = 1'b1;
        end
        // Held while rready is low
        rvalid  = r_busy;
        rdata   = DATA_WIDTH'(cur_addr) + DATA_WIDTH'(beat_idx);
        rlast   = r_busy && (beat_idx == cur_len);
        // AR back-pressure about one cycle in four
        arready = ($urandom % 4) != 0;
    end

    // ==========================================================
    // Driver tasks
    // ==========================================================

    task automatic write_csr(input logic [CSR_IDX_WIDTH-1:0] idx, input logic [63:0] data);
        @(posedge clk);
        #1;
        csr_wr   = 1'b1;
        csr_idx  = idx;
        csr_data = data;
        @(posedge clk);
        #1;
        csr_wr   = 1'b0;
    endtask

    task automatic configure(input logic [ADDR_WIDTH-1:0] base, input logic [15:0] max_lines,
                             input logic [15:0] bursts, input logic [15:0] start,
                             input logic [15:0] len, input logic [31:0] mask);
        write_csr(CSR_BASE_ADDR, 64'(base));
        // Max lines, bursts, start offset, burst length
        write_csr(CSR_RD_CTRL, {max_lines, bursts, start, len});
        write_csr(CSR_OFFSET_MASK, 64'(mask));
    endtask

    // Two reset cycles, the ready mask goes in with them
    task automatic apply_reset(input logic [31:0] mask);
        @(posedge clk);
        #1;
        mask_load   = mask;
        state_reset = 1'b1;
        csr_wr      = 1'b1;
        csr_idx     = CSR_READY_MASK;
        csr_data    = 64'(mask);
        repeat (2) @(posedge clk);
        #1;
        state_reset = 1'b0;
        csr_wr      = 1'b0;
    endtask

    task automatic read_status(input logic [CSR_IDX_WIDTH-1:0] idx, output logic [63:0] value);
        @(posedge clk);
        #1;
        csr_rd_idx = idx;
        @(negedge clk);
        value = csr_rd_data;
    endtask

    // Raise run, wait for active to fall, let the counters catch up
    task automatic run_until_idle();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        run        = 1'b1;
        csr_rd_idx = STS_ACTIVE;
        @(negedge clk);
        while (csr_rd_data[0] && (cycles < IDLE_LIMIT))
        begin
            @(negedge clk);
            cycles++;
        end
        if (csr_rd_data[0])
        begin
            $display("%s: engine still active after %0d cycles", test_name, IDLE_LIMIT);
            errors++;
        end
        @(posedge clk);
        #1;
        run = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // ==========================================================
    // Tests
    // ==========================================================

    task automatic test_address_sequence();
        logic [ADDR_WIDTH-1:0] expected [5];
        test_name = "address_sequence";
        tests_run++;
        // Offset 4 steps by 4 inside mask 0xF, so it wraps after 0xC
        expected = '{48'h1004, 48'h1008, 48'h100C, 48'h1000, 48'h1004};
        configure(48'h1000, 16'd0, 16'd5, 16'd4, 16'd4, 32'hF);
        apply_reset(32'hFFFF_FFFF);
        run_until_idle();
        if (seen_addr.size() != 5)
        begin
            $display("mismatch %s: bursts expected 5 actual %0d", test_name, seen_addr.size());
            errors++;
        end
        for (int i = 0; (i < seen_addr.size()) && (i < 5); i++)
        begin
            if (seen_addr[i] !== expected[i])
            begin
                $display("mismatch %s: burst %0d expected %0h actual %0h",
                         test_name, i, expected[i], seen_addr[i]);
                errors++;
            end
        end
    endtask

    task automatic test_statistics();
        logic [63:0] value;
        test_name = "statistics";
        tests_run++;
        read_status(STS_BURSTS_REQ, value);
        if (value !== 64'd5)
        begin
            $display("mismatch %s: bursts requested expected 5 actual %0d", test_name, value);
            errors++;
        end
        read_status(STS_LINES_RESP, value);
        if (value !== 64'd20)
        begin
            $display("mismatch %s: lines received expected 20 actual %0d", test_name, value);
            errors++;
        end
        read_status(STS_BURSTS_RESP, value);
        if (value !== 64'd5)
        begin
            $display("mismatch %s: bursts completed expected 5 actual %0d", test_name, value);
            errors++;
        end
        // Lines in flight summed over every cycle since reset
        read_status(STS_ACTIVE_LINES, value);
        if (value !== 64'(line_cycle_sum))
        begin
            $display("mismatch %s: line-cycle sum expected %0d actual %0d",
                     test_name, line_cycle_sum, value);
            errors++;
        end
    endtask

    task automatic test_sum_hash();
        logic [63:0] value;
        test_name = "sum_hash";
        tests_run++;
        read_status(STS_CHECK, value);
        if (value !== {exp_sum, exp_hash})
        begin
            $display("mismatch %s: expected %h actual %h", test_name, {exp_sum, exp_hash}, value);
            errors++;
        end
    endtask

    task automatic test_line_quota();
        test_name = "line_quota";
        tests_run++;
        configure(48'h2000, 16'd4, 16'd8, 16'd0, 16'd4, 32'hFF);
        apply_reset(32'hFFFF_FFFF);
        run_until_idle();
        // Quota of 4 may be overshot by at most one burst
        if (peak_in_flight > 4 + 4)
        begin
            $display("mismatch %s: peak lines expected <= 8 actual %0d", test_name, peak_in_flight);
            errors++;
        end
        if ((last_count != 8) || (beat_count != 32))
        begin
            $display("mismatch %s: bursts/beats expected 8/32 actual %0d/%0d",
                     test_name, last_count, beat_count);
            errors++;
        end
    endtask

    task automatic test_ready_mask();
        test_name = "ready_mask";
        tests_run++;
        configure(48'h3000, 16'd0, 16'd6, 16'd0, 16'd4, 32'hFFFF);
        apply_reset(32'h5555_5555);
        run_until_idle();
        if ((seen_addr.size() != 6) || (beat_count != seen_addr.size() * 4))
        begin
            $display("mismatch %s: beats expected %0d actual %0d",
                     test_name, seen_addr.size() * 4, beat_count);
            errors++;
        end
    endtask

    task automatic test_zero_base();
        logic [63:0] value;
        test_name = "zero_base";
        tests_run++;
        configure(48'h0, 16'd0, 16'd3, 16'd0, 16'd4, 32'hF);
        apply_reset(32'hFFFF_FFFF);
        read_status(STS_ACTIVE, value);
        if (value[0] !== 1'b0)
        begin
            $display("mismatch %s: active after reset expected 0 actual %0b", test_name, value[0]);
            errors++;
        end
        @(posedge clk);
        #1;
        run = 1'b1;
        repeat (20) @(posedge clk);
        if (seen_addr.size() != 0)
        begin
            $display("mismatch %s: bursts expected 0 actual %0d", test_name, seen_addr.size());
            errors++;
        end
        read_status(STS_ACTIVE, value);
        if (value[0] !== 1'b0)
        begin
            $display("mismatch %s: active while running expected 0 actual %0b", test_name, value[0]);
            errors++;
        end
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    // ==========================================================
    // Sequence, watchdog and report
    // ==========================================================

    initial
    begin
        void'($urandom(SEED));
        state_reset = 1'b0;
        run         = 1'b0;
        csr_wr      = 1'b0;
        csr_idx     = '0;
        csr_data    = '0;
        csr_rd_idx  = '0;
        mask_load   = '1;
        errors      = 0;
        tests_run   = 0;
        test_address_sequence();
        test_statistics();
        test_sum_hash();
        test_line_quota();
        test_ready_mask();
        test_zero_base();
        $display("tests run: %0d, errors: %0d", tests_run, errors + mask_errors);
        if ((errors + mask_errors) == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial
    begin
        repeat (TEST_CYCLES * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", TEST_CYCLES * 20);
        $display("tests run: %0d, errors: %0d", tests_run, errors + mask_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: files.f
engine_pkg.sv
stat_counter.sv
rd_engine_csr.sv
rd_req_gen.sv
rd_line_tracker.sv
rd_resp_sink.sv
rd_engine_top.sv
rd_engine_properties.sv
tb_rd_engine.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the read engine testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rd_engine -f files.f -o sim_rd_engine \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_rd_engine > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"
